//--- source/audio_pkg.sv
////////////////////////////////////////////////////////////
// Audio types for the stereo mix path
// Sample widths, attenuation, crossfeed mode and the
// structs that carry core and host PCM samples
////////////////////////////////////////////////////////////

package audio_pkg;

	// One audio sample and the guarded sum width
	typedef logic [15:0] sample_t;
	typedef logic [16:0] wide_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] att_t;

	// Crossfeed mode
	typedef logic [1:0] mix_t;

	localparam mix_t MIX_NONE    = 2'd0;
	localparam mix_t MIX_QUARTER = 2'd1;
	localparam mix_t MIX_HALF    = 2'd2;
	localparam mix_t MIX_EQUAL   = 2'd3;

	// Core side samples with their format and mode
	typedef struct packed {
		sample_t left;
		sample_t right;
		logic    is_signed;
		mix_t    mix;
	} core_audio_t;

	// Host PCM samples, always signed
	typedef struct packed {
		sample_t left;
		sample_t right;
	} pcm_t;

endpackage

//--- source/host_pkg.sv
////////////////////////////////////////////////////////////
// Host command port types
// Word and command widths, command codes, the strobed
// host bus and the command decoder states
////////////////////////////////////////////////////////////

package host_pkg;

	// One word as sent by the host
	typedef logic [15:0] host_word_t;

	// Command code, taken from the low byte of the first word
	typedef logic [7:0] cmd_t;

	// Volume command, data word bits 4:0 hold the attenuation
	localparam cmd_t CMD_VOLUME = 8'h26;

	// Host bus, a word is valid on each strobe edge while sel is high
	typedef struct packed {
		logic       sel;
		logic       strobe;
		host_word_t data;
	} host_bus_t;

	// Waiting for a command word, or taking its data words
	typedef enum logic {
		IDLE,
		HAVE_CMD
	} host_state_e;

endpackage

//--- source/host_cmd_port.sv
////////////////////////////////////////////////////////////
// Host command port
// Takes strobed words from the host, keeps the volume
// attenuation register and echoes the strobe as ack
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module host_cmd_port
	import audio_pkg::*;
	import host_pkg::*;
(
	input  logic      clk,
	input  logic      resetd,
	input  host_bus_t i_host,
	output logic      o_host_ack,
	output att_t      o_att
);

	// Strobe and select, two register stages
	logic       strobe_s1;
	logic       strobe_s2;
	logic       sel_s1;
	host_word_t data_s1;
	logic       word_rise;

	// Decoder state
	host_state_e state_q;
	cmd_t        cmd_q;
	att_t        att_q;

	////////////////////////////////////////////////////////////
	// Input stage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_s1 <= 1'b0;
			strobe_s2 <= 1'b0;
			sel_s1    <= 1'b0;
		end else begin
			strobe_s1 <= i_host.strobe;
			strobe_s2 <= strobe_s1;
			sel_s1    <= i_host.sel;
		end
	end

	// Data word lines up with sel_s1 and the edge below
	always_ff @(posedge clk) begin
		data_s1 <= i_host.data;
	end

	// One pulse per host word
	assign word_rise = strobe_s1 & ~strobe_s2;

	////////////////////////////////////////////////////////////
	// Command decoder
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state_q <= IDLE;
			cmd_q   <= '0;
			att_q   <= '0;
		end else if (!sel_s1) begin
			// Select dropped, next word starts a new command
			state_q <= IDLE;
			cmd_q   <= '0;
		end else if (word_rise) begin
			case (state_q)
				IDLE: begin
					cmd_q   <= data_s1[7:0];
					state_q <= HAVE_CMD;
				end
				HAVE_CMD: begin
					// Each data word reloads the volume, other commands are ignored
					if (cmd_q == CMD_VOLUME) begin
						att_q <= data_s1[4:0];
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Ack follows the strobe two cycles later, never stalled
	assign o_host_ack = strobe_s2;
	assign o_att      = att_q;

endmodule

//--- source/mix_channel.sv
////////////////////////////////////////////////////////////
// Mixer channel
// Settle filter on the core sample, sum with host PCM,
// crossfeed, attenuation and clamp to 16 bits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mix_channel
	import audio_pkg::*;
#(
	parameter int SETTLE_DEPTH = 2
)
(
	input  logic    clk,
	input  logic    resetd,
	input  sample_t i_core_sample,
	input  logic    i_is_signed,
	input  mix_t    i_mix,
	input  sample_t i_pcm,
	input  sample_t i_pre,
	input  att_t    i_att,
	output sample_t o_pre,
	output sample_t o_sample
);

	// Settle filter
	sample_t [SETTLE_DEPTH-1:0] settle_q;
	logic                       taps_equal;
	sample_t                    core_q;

	// Pipeline registers
	wide_t   wide_q;
	wide_t   sum_q;
	wide_t   blend_q;
	wide_t   att_q;
	sample_t pre_q;
	sample_t out_q;

	// Stage logic
	logic signed [16:0] sum_s;
	logic signed [16:0] pre_s;
	logic signed [16:0] blend_d;
	logic signed [16:0] att_d;

	////////////////////////////////////////////////////////////
	// Settle filter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			settle_q <= '0;
		end else begin
			settle_q[0] <= i_core_sample;
			for (int i = 1; i < SETTLE_DEPTH; i++) begin
				settle_q[i] <= settle_q[i-1];
			end
		end
	end

	// All taps must hold the same value
	always_comb begin
		taps_equal = 1'b1;
		for (int i = 1; i < SETTLE_DEPTH; i++) begin
			if (settle_q[i] != settle_q[0]) begin
				taps_equal = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_q <= '0;
		end else if (taps_equal) begin
			core_q <= settle_q[SETTLE_DEPTH-1];
		end
	end

	////////////////////////////////////////////////////////////
	// Crossfeed and attenuation
	////////////////////////////////////////////////////////////

	assign sum_s = $signed(sum_q);
	assign pre_s = $signed({i_pre[15], i_pre});

	always_comb begin
		case (i_mix)
			MIX_NONE:    blend_d = sum_s;
			MIX_QUARTER: blend_d = sum_s - (sum_s >>> 3) + (pre_s >>> 2);
			MIX_HALF:    blend_d = sum_s - (sum_s >>> 2) + (pre_s >>> 1);
			MIX_EQUAL:   blend_d = (sum_s >>> 1) + pre_s;
			default:     blend_d = sum_s;
		endcase
	end

	// Mute wins over the shift count
	assign att_d = i_att[4] ? 17'sd0 : ($signed(blend_q) >>> i_att[3:0]);

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			wide_q  <= '0;
			sum_q   <= '0;
			pre_q   <= '0;
			blend_q <= '0;
			att_q   <= '0;
			out_q   <= '0;
		end else begin
			// Unsigned samples are halved to fit the signed range
			wide_q <= i_is_signed ? {core_q[15], core_q} : {2'b00, core_q[15:1]};

			sum_q <= wide_q + {i_pcm[15], i_pcm};

			// Half of the sum goes to the other channel
			pre_q <= sum_q[16:1];

			blend_q <= blend_d;
			att_q   <= att_d;

			// Saturate when bits 16 and 15 disagree
			if (att_q[16] != att_q[15]) begin
				out_q <= att_q[16] ? 16'h8000 : 16'h7FFF;
			end else begin
				out_q <= att_q[15:0];
			end
		end
	end

	assign o_pre    = pre_q;
	assign o_sample = out_q;

endmodule

//--- source/audio_mix_top.sv
////////////////////////////////////////////////////////////
// Stereo audio mixer top level
// Host command port plus two cross-coupled mix channels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_mix_top
	import audio_pkg::*;
	import host_pkg::*;
#(
	parameter int SETTLE_DEPTH = 2
)
(
	input  logic        clk,
	input  logic        resetd,
	input  host_bus_t   i_host,
	input  core_audio_t i_core,
	input  pcm_t        i_pcm,
	output logic        o_host_ack,
	output sample_t     o_left,
	output sample_t     o_right
);

	att_t    att;
	sample_t left_pre;
	sample_t right_pre;

	// Host side, volume register
	host_cmd_port u_host (
		.clk        (clk),
		.resetd     (resetd),
		.i_host     (i_host),
		.o_host_ack (o_host_ack),
		.o_att      (att)
	);

	////////////////////////////////////////////////////////////
	// Channels, each takes half of the other's sum
	////////////////////////////////////////////////////////////

	mix_channel #(
		.SETTLE_DEPTH (SETTLE_DEPTH)
	) u_left (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_sample (i_core.left),
		.i_is_signed   (i_core.is_signed),
		.i_mix         (i_core.mix),
		.i_pcm         (i_pcm.left),
		.i_pre         (right_pre),
		.i_att         (att),
		.o_pre         (left_pre),
		.o_sample      (o_left)
	);

	mix_channel #(
		.SETTLE_DEPTH (SETTLE_DEPTH)
	) u_right (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_sample (i_core.right),
		.i_is_signed   (i_core.is_signed),
		.i_mix         (i_core.mix),
		.i_pcm         (i_pcm.right),
		.i_pre         (left_pre),
		.i_att         (att),
		.o_pre         (right_pre),
		.o_sample      (o_right)
	);

endmodule

//--- tests/audio_mix_chk.sv
////////////////////////////////////////////////////////////
// Host command port checker
// Reset values, strobe echo on ack and volume updates
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module audio_mix_chk
	import audio_pkg::*;
	import host_pkg::*;
(
	input logic        clk,
	input logic        resetd,
	input host_bus_t   i_host,
	input logic        i_ack,
	input att_t        i_att,
	input host_state_e i_state,
	input cmd_t        i_cmd
);

	// Reset clears the ack and the attenuation
	ack_reset: assert property (@(posedge clk) resetd |=> (i_ack == 1'b0 && i_att == '0))
		else $error("Ack or attenuation not cleared by reset");

	// Ack repeats the strobe level two cycles later
	ack_echo: assert property (@(posedge clk) disable iff (resetd)
		(!$past(resetd, 1) && !$past(resetd, 2)) |-> (i_ack == $past(i_host.strobe, 2)))
		else $error("Ack does not follow the strobe by two cycles");

	// Volume only moves while a command is held
	att_in_cmd: assert property (@(posedge clk) disable iff (resetd)
		(i_att != $past(i_att)) |-> ($past(i_state) == HAVE_CMD))
		else $error("Attenuation changed outside HAVE_CMD");

	// Mute comes only from a volume command
	mute_from_volume: assert property (@(posedge clk) disable iff (resetd)
		$rose(i_att[4]) |-> ($past(i_cmd) == CMD_VOLUME))
		else $error("Mute set by a command other than volume");

endmodule

bind host_cmd_port audio_mix_chk u_chk (
	.clk     (clk),
	.resetd  (resetd),
	.i_host  (i_host),
	.i_ack   (o_host_ack),
	.i_att   (o_att),
	.i_state (state_q),
	.i_cmd   (cmd_q)
);

//--- tests/tb_audio_mix.sv
////////////////////////////////////////////////////////////
// Testbench for the stereo audio mixer
// Table-driven stimulus with host volume writes, a sample
// reference model, compare tasks and a watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_audio_mix
	import audio_pkg::*;
	import host_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES  = 16;
	localparam int ENTRY_CYCLES = 40;
	localparam int DRIVE_DELAY  = 5;
	localparam cmd_t CMD_OTHER  = 8'h27;

	// Host action done before an entry's samples are applied
	typedef logic [1:0] host_op_t;
	localparam host_op_t HOST_NONE      = 2'd0;
	localparam host_op_t HOST_VOLUME    = 2'd1;
	localparam host_op_t HOST_SEL_LOW   = 2'd2;
	localparam host_op_t HOST_OTHER_CMD = 2'd3;

	typedef struct packed {
		host_op_t    op;
		att_t        vol;
		core_audio_t core;
		pcm_t        pcm;
		sample_t     exp_left;
		sample_t     exp_right;
	} entry_t;

	logic        clk;
	logic        resetd;
	host_bus_t   host;
	core_audio_t core;
	pcm_t        pcm;
	logic        host_ack;
	sample_t     left;
	sample_t     right;

	entry_t table_q[$];
	string  name_q[$];
	logic   table_ready = 1'b0;
	att_t   model_att   = '0;
	int     seed        = 34;
	int     tests       = 0;
	int     checks      = 0;
	int     errors      = 0;
	int     test_errors = 0;

	audio_mix_top #(
		.SETTLE_DEPTH (2)
	) dut (
		.clk        (clk),
		.resetd     (resetd),
		.i_host     (host),
		.i_core     (core),
		.i_pcm      (pcm),
		.o_host_ack (host_ack),
		.o_left     (left),
		.o_right    (right)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic int widen(sample_t s, logic is_signed);
		int w;
		if (is_signed) begin
			w = int'($signed(s));
		end else begin
			// Unsigned samples drop their low bit
			w = int'(s >> 1);
		end
		return w;
	endfunction

	function automatic sample_t mix_ref(core_audio_t c, pcm_t p, logic is_left, att_t att);
		int s_l;
		int s_r;
		int s_own;
		int p_other;
		int r;
		s_l     = widen(c.left, c.is_signed) + int'($signed(p.left));
		s_r     = widen(c.right, c.is_signed) + int'($signed(p.right));
		s_own   = is_left ? s_l : s_r;
		p_other = (is_left ? s_r : s_l) >>> 1;
		case (c.mix)
			MIX_QUARTER: r = s_own - (s_own >>> 3) + (p_other >>> 2);
			MIX_HALF:    r = s_own - (s_own >>> 2) + (p_other >>> 1);
			MIX_EQUAL:   r = (s_own >>> 1) + p_other;
			default:     r = s_own;
		endcase
		r = att[4] ? 0 : (r >>> att[3:0]);
		if (r > 32767) begin
			r = 32767;
		end else if (r < -32768) begin
			r = -32768;
		end
		return r[15:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	function automatic core_audio_t core_of(sample_t l, sample_t r, logic sgn, mix_t m);
		core_audio_t c;
		c.left      = l;
		c.right     = r;
		c.is_signed = sgn;
		c.mix       = m;
		return c;
	endfunction

	function automatic pcm_t pcm_of(sample_t l, sample_t r);
		pcm_t p;
		p.left  = l;
		p.right = r;
		return p;
	endfunction

	task automatic add_entry(string name, host_op_t op, att_t vol, core_audio_t c, pcm_t p);
		entry_t e;
		if (op == HOST_VOLUME) begin
			model_att = vol;
		end
		e.op        = op;
		e.vol       = vol;
		e.core      = c;
		e.pcm       = p;
		e.exp_left  = mix_ref(c, p, 1'b1, model_att);
		e.exp_right = mix_ref(c, p, 1'b0, model_att);
		table_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic build_table();
		add_entry("signed_sum", HOST_NONE, '0,
			core_of(16'h1000, 16'hF000, 1'b1, MIX_NONE), pcm_of(16'h0200, 16'h0100));
		add_entry("unsigned_sum", HOST_NONE, '0,
			core_of(16'hC000, 16'h2001, 1'b0, MIX_NONE), pcm_of(16'hFF00, 16'h0040));
		for (int i = 0; i < 4; i++) begin
			add_entry($sformatf("random_pcm_%0d", i), HOST_NONE, '0,
				core_of(16'h2345, 16'hA0C0, i[0], MIX_NONE),
				pcm_of(16'($random(seed)), 16'($random(seed))));
		end
		add_entry("sat_pos", HOST_NONE, '0,
			core_of(16'h7FFF, 16'h7000, 1'b1, MIX_NONE), pcm_of(16'h7FFF, 16'h7FFF));
		add_entry("sat_neg", HOST_NONE, '0,
			core_of(16'h8000, 16'h9000, 1'b1, MIX_NONE), pcm_of(16'h8000, 16'h8001));
		add_entry("vol_shift_2", HOST_VOLUME, 5'd2,
			core_of(16'h4000, 16'hC000, 1'b1, MIX_NONE), pcm_of(16'h0100, 16'hFF00));
		add_entry("vol_shift_5", HOST_VOLUME, 5'd5,
			core_of(16'h1234, 16'hE001, 1'b1, MIX_NONE), pcm_of(16'h0333, 16'hFFF1));
		add_entry("vol_sel_low", HOST_SEL_LOW, 5'h11,
			core_of(16'h0F00, 16'hF100, 1'b1, MIX_NONE), pcm_of(16'h0010, 16'h0020));
		add_entry("vol_other_cmd", HOST_OTHER_CMD, 5'h10,
			core_of(16'h5000, 16'h3000, 1'b0, MIX_NONE), pcm_of(16'h0100, 16'hFE00));
		add_entry("vol_mute", HOST_VOLUME, 5'h13,
			core_of(16'h2000, 16'hD000, 1'b1, MIX_NONE), pcm_of(16'h0400, 16'h0500));
		add_entry("vol_zero", HOST_VOLUME, 5'd0,
			core_of(16'h2000, 16'hD000, 1'b1, MIX_NONE), pcm_of(16'h0400, 16'h0500));
		add_entry("mix_quarter", HOST_NONE, '0,
			core_of(16'h3000, 16'h0800, 1'b1, MIX_QUARTER), pcm_of(16'h0100, 16'hFE00));
		add_entry("mix_half", HOST_NONE, '0,
			core_of(16'hD000, 16'h2400, 1'b1, MIX_HALF), pcm_of(16'h0777, 16'h0123));
		add_entry("mix_equal", HOST_NONE, '0,
			core_of(16'h6000, 16'h9000, 1'b1, MIX_EQUAL), pcm_of(16'h1000, 16'hF000));
		add_entry("mix_equal_unsigned", HOST_NONE, '0,
			core_of(16'hF000, 16'h1000, 1'b0, MIX_EQUAL), pcm_of(16'h7000, 16'h0200));
	endtask

	////////////////////////////////////////////////////////////
	// Host port and compare tasks
	////////////////////////////////////////////////////////////

	task automatic next_drive_slot();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic check_sample(string name, sample_t expected, sample_t actual);
		checks++;
		if (actual !== expected) begin
			$display("Fail %s: expected %h (%0d), actual %h (%0d)", name,
				expected, $signed(expected), actual, $signed(actual));
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_ack(string name, logic expected, logic actual);
		checks++;
		if (actual !== expected) begin
			$display("Fail %s: expected ack %b, actual %b", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// Ack must reach the strobe level within a few cycles
	task automatic wait_ack(string name, logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (host_ack !== level && n < 8) begin
			@(negedge clk);
			n++;
		end
		check_ack({name, "/ack"}, level, host_ack);
	endtask

	task automatic send_word(string name, host_word_t w);
		next_drive_slot();
		host.data   = w;
		host.strobe = 1'b1;
		wait_ack(name, 1'b1);
		next_drive_slot();
		host.strobe = 1'b0;
		wait_ack(name, 1'b0);
	endtask

	task automatic run_host_op(string name, host_op_t op, att_t vol);
		case (op)
			HOST_VOLUME, HOST_OTHER_CMD: begin
				next_drive_slot();
				host.sel = 1'b1;
				send_word(name, {8'h00, (op == HOST_VOLUME) ? CMD_VOLUME : CMD_OTHER});
				send_word(name, {11'h000, vol});
				next_drive_slot();
				host.sel = 1'b0;
			end
			HOST_SEL_LOW: begin
				send_word(name, {11'h000, vol});
			end
			default: begin
			end
		endcase
	endtask

	task automatic report_test(string name);
		tests++;
		if (test_errors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		entry_t e;
		resetd = 1'b1;
		// Inputs held nonzero through reset
		host        = '0;
		host.strobe = 1'b1;
		core        = core_of(16'h1234, 16'h8765, 1'b1, MIX_EQUAL);
		pcm         = pcm_of(16'h0456, 16'hFEDC);
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY resetd = 1'b0;
		@(negedge clk);
		check_sample("reset/left", 16'h0000, left);
		check_sample("reset/right", 16'h0000, right);
		check_ack("reset/ack", 1'b0, host_ack);
		report_test("reset");
		next_drive_slot();
		host = '0;
		for (int i = 0; i < table_q.size(); i++) begin
			e = table_q[i];
			run_host_op(name_q[i], e.op, e.vol);
			next_drive_slot();
			core = e.core;
			pcm  = e.pcm;
			repeat (HOLD_CYCLES) @(posedge clk);
			@(negedge clk);
			check_sample({name_q[i], "/left"}, e.exp_left, left);
			check_sample({name_q[i], "/right"}, e.exp_right, right);
			report_test(name_q[i]);
		end
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = table_q.size() * ENTRY_CYCLES + RESET_CYCLES;
		repeat (limit) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clock cycles", limit);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- build.f
source/audio_pkg.sv
source/host_pkg.sv
source/host_cmd_port.sv
source/mix_channel.sv
source/audio_mix_top.sv
tests/audio_mix_chk.sv
tests/tb_audio_mix.sv

//--- Makefile
# Verilator build and run for the stereo audio mixer

VERILATOR  ?= verilator
TOP        ?= tb_audio_mix
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Verification failed
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the failure message, a crash also fails
run: build
	@./$(BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
